/* Bender.yml */
package:
  name: eeprom_sub

sources:
  - eeprom_geom_pkg.sv
  - i2c_bus_pkg.sv
  - bank_port_if.sv
  - i2c_target.sv
  - eeprom_bank.sv
  - read_return.sv
  - eeprom_top.sv
  - target: test
    files:
      - eeprom_tb.sv

/* bank_port_if.sv */
`timescale 1ns/1ns
`default_nettype none

interface bank_port_if;

    logic                       cmd_valid;
    eeprom_geom_pkg::bank_cmd_t cmd;

    // one pulse for every queue entry the bank has finished with.
    logic                       credit;

    logic                       rd_valid;
    logic [7:0]                 rd_data;

    modport issuer (
        output cmd_valid,
        output cmd,
        input  credit
    );

    modport server (
        input  cmd_valid,
        input  cmd,
        output credit,
        output rd_valid,
        output rd_data
    );

    modport reader (
        input rd_valid,
        input rd_data
    );

endinterface

`default_nettype wire

/* eeprom_bank.sv */
`timescale 1ns/1ns
`default_nettype none

module eeprom_bank (
    input  logic        sda,
    input  logic        rst_n,
    bank_port_if.server port
);
    import eeprom_geom_pkg::*;

    bank_cmd_t              queue [QUEUE_DEPTH];
    logic [QUEUE_BITS-1:0]  wr_ptr;
    logic [QUEUE_BITS-1:0]  rd_ptr;
    logic [CREDIT_BITS-1:0] count;
    logic [7:0]             mem [2**OFFSET_BITS];
    logic [BUSY_BITS-1:0]   busy_cnt;
    logic                   busy;
    logic                   take;
    bank_cmd_t              head;

    assign head = queue[rd_ptr];
    assign busy = busy_cnt != '0;
    assign take = (count != '0) && !busy;

    always_ff @(posedge sda)
    begin
        if (port.cmd_valid)
            queue[wr_ptr] <= port.cmd;
    end

    always_ff @(posedge sda)
    begin
        if (!rst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (port.cmd_valid)
                wr_ptr <= wr_ptr + 1'b1;
            if (take)
                rd_ptr <= rd_ptr + 1'b1;
            case ({port.cmd_valid, take})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // the array sees commands in queue order, so a read after a write gets the new byte.
    always_ff @(posedge sda)
    begin
        if (take && head.write)
            mem[head.offset] <= head.data;
        if (take && !head.write)
            port.rd_data <= mem[head.offset];
    end

    always_ff @(posedge sda)
    begin
        if (!rst_n)
        begin
            busy_cnt      <= '0;
            port.rd_valid <= 1'b0;
            port.credit   <= 1'b0;
        end
        else
        begin
            if (take && head.write)
                busy_cnt <= BUSY_BITS'(WRITE_CYCLES);
            else if (busy)
                busy_cnt <= busy_cnt - 1'b1;
            port.rd_valid <= take && !head.write;
            // a write frees its entry when the store cycle ends, a read at once.
            port.credit   <= (busy_cnt == BUSY_BITS'(1)) || (take && !head.write);
        end
    end

endmodule

`default_nettype wire

/* eeprom_geom_pkg.sv */
`default_nettype none

package eeprom_geom_pkg;

    // eight blocks of 256 bytes make up the 2048-byte array.
    localparam int NUM_BANKS   = 8;
    localparam int BANK_BITS   = 3;
    localparam int OFFSET_BITS = 8;

    // queue entries per bank, and also the credits the target starts with.
    localparam int QUEUE_DEPTH = 4;
    localparam int QUEUE_BITS  = $clog2(QUEUE_DEPTH);
    localparam int CREDIT_BITS = $clog2(QUEUE_DEPTH + 1);

    // clocks a bank stays busy after storing one byte.
    localparam int WRITE_CYCLES = 400;
    localparam int BUSY_BITS    = $clog2(WRITE_CYCLES + 1);

    // a read command only uses the offset field.
    typedef struct packed {
        logic                   write;
        logic [OFFSET_BITS-1:0] offset;
        logic [7:0]             data;
    } bank_cmd_t;

endpackage

`default_nettype wire

/* eeprom_sub.f */
eeprom_geom_pkg.sv
i2c_bus_pkg.sv
bank_port_if.sv
i2c_target.sv
eeprom_bank.sv
read_return.sv
eeprom_top.sv
eeprom_tb.sv

/* eeprom_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module eeprom_tb;
    import eeprom_geom_pkg::*;
    import i2c_bus_pkg::*;

    localparam int          DRIVE_DELAY   = 1;
    localparam int          STRETCH_LIMIT = 2 * (QUEUE_DEPTH + 1) * WRITE_CYCLES;
    localparam int          DRAIN_LIMIT   = 100;
    localparam logic [31:0] RNG_SEED      = 32'heabd911b;

    logic sda;
    logic rst_n;
    logic scl_m;
    logic data_m;
    wire  bus_scl;
    wire  bus_data;
    wire  bus_data_low;
    wire  bus_scl_low;

    logic [7:0]             ref_mem [NUM_BANKS * 2**OFFSET_BITS];
    logic [BANK_BITS-1:0]   ref_bank;
    logic [OFFSET_BITS-1:0] ref_off;
    logic [7:0]             got_q [$];
    logic [7:0]             exp_q [$];
    int                     stretch_clocks = 0;
    int                     bytes_checked = 0;

    // open-drain lines are the AND of the master and the DUT pull-downs.
    assign bus_scl  = scl_m & ~bus_scl_low;
    assign bus_data = data_m & ~bus_data_low;

    eeprom_top DUT (
        .sda          (sda),
        .rst_n        (rst_n),
        .bus_scl      (bus_scl),
        .bus_data     (bus_data),
        .bus_data_low (bus_data_low),
        .bus_scl_low  (bus_scl_low)
    );

    always #10 sda = ~sda;

    always @(posedge sda)
    begin
        if (bus_scl_low === 1'b1)
            stretch_clocks <= stretch_clocks + 1;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_ack(input string name, input logic got, input logic exp);
        if (got !== exp)
            abort_run($sformatf("Mismatch at %0t ns: %s is %b, expected %b",
                                $time, name, got, exp));
    endtask

    task automatic check_byte(
        input string      name,
        input logic [7:0] got,
        input logic [7:0] exp
    );
        if (got !== exp)
            abort_run($sformatf("Mismatch at %0t ns: %s is 8'h%h, expected 8'h%h",
                                $time, name, got, exp));
    endtask

    // the expected byte sits at the pointer, and the offset then wraps inside the bank.
    function automatic logic [7:0] ref_read();
        logic [7:0] value;
        value   = ref_mem[{ref_bank, ref_off}];
        ref_off = ref_off + 1'b1;
        return value;
    endfunction

    function automatic void ref_write(input logic [7:0] value);
        ref_mem[{ref_bank, ref_off}] = value;
        ref_off = ref_off + 1'b1;
    endfunction

    function automatic logic [7:0] control_byte(input logic [BANK_BITS-1:0] bank, input logic rw);
        return {DEVICE_CODE, bank, rw};
    endfunction

    task automatic tick(input int n);
        repeat (n) @(posedge sda);
        #(DRIVE_DELAY);
    endtask

    task automatic wait_scl_released();
        int waited;
        waited = 0;
        while (bus_scl !== 1'b1)
        begin
            if (waited == STRETCH_LIMIT)
                abort_run("SCL was held low by the DUT for too long");
            tick(1);
            waited++;
        end
    endtask

    // one SCL period of ten clocks, with the line sampled late in the high phase.
    task automatic clock_bit(input logic drive, output logic seen);
        scl_m = 1'b0;
        tick(1);
        data_m = drive;
        tick(4);
        scl_m = 1'b1;
        tick(1);
        wait_scl_released();
        tick(2);
        seen = bus_data;
        tick(2);
    endtask

    task automatic send_start();
        scl_m = 1'b0;
        tick(1);
        data_m = 1'b1;
        tick(4);
        scl_m = 1'b1;
        tick(5);
        data_m = 1'b0;
        tick(5);
    endtask

    task automatic send_stop();
        scl_m = 1'b0;
        tick(1);
        data_m = 1'b0;
        tick(4);
        scl_m = 1'b1;
        tick(5);
        data_m = 1'b1;
        tick(5);
    endtask

    task automatic send_byte(input logic [7:0] value, output logic ack);
        logic seen;
        for (int i = 7; i >= 0; i--)
            clock_bit(value[i], seen);
        clock_bit(1'b1, ack);
    endtask

    task automatic recv_byte(input logic last, output logic [7:0] value);
        logic seen;
        for (int i = 7; i >= 0; i--)
        begin
            clock_bit(1'b1, seen);
            value[i] = seen;
        end
        clock_bit(last ? NACK_BIT : ACK_BIT, seen);
    endtask

    task automatic send_checked(input logic [7:0] value, input logic exp_ack, input string name);
        logic ack;
        send_byte(value, ack);
        check_ack(name, ack, exp_ack);
    endtask

    task automatic open_write(
        input logic [BANK_BITS-1:0]   bank,
        input logic [OFFSET_BITS-1:0] offset
    );
        send_start();
        send_checked(control_byte(bank, 1'b0), ACK_BIT, "control byte acknowledge");
        send_checked(offset, ACK_BIT, "address byte acknowledge");
        ref_bank = bank;
        ref_off  = offset;
    endtask

    task automatic write_checked(input logic [7:0] value);
        send_checked(value, ACK_BIT, "data byte acknowledge");
        ref_write(value);
    endtask

    // after open_write this START is a repeated START, otherwise a current-address read.
    task automatic read_bytes(input logic [BANK_BITS-1:0] bank, input int count);
        logic [7:0] value;
        send_start();
        send_checked(control_byte(bank, RW_READ), ACK_BIT, "read control acknowledge");
        ref_bank = bank;
        for (int i = 0; i < count; i++)
        begin
            recv_byte(i == count - 1, value);
            got_q.push_back(value);
            exp_q.push_back(ref_read());
        end
        send_stop();
    endtask

    task automatic write_then_read(
        input logic [BANK_BITS-1:0]   bank,
        input logic [OFFSET_BITS-1:0] offset,
        input logic [7:0]             value
    );
        open_write(bank, offset);
        write_checked(value);
        send_stop();
        open_write(bank, offset);
        read_bytes(bank, 1);
    endtask

    always @(posedge sda)
    begin
        if (got_q.size() != 0 && exp_q.size() != 0)
        begin
            check_byte("read data", got_q.pop_front(), exp_q.pop_front());
            bytes_checked <= bytes_checked + 1;
        end
    end

    initial
    begin : test_sequence
        logic [BANK_BITS-1:0]   bank1;
        logic [OFFSET_BITS-1:0] off1;
        logic [BANK_BITS-1:0]   bank;
        logic [OFFSET_BITS-1:0] start;
        logic [7:0]             value;
        logic                   ack;
        logic                   seen;
        logic [3:0]             bad_code;
        int                     acked;
        int                     stretch_before;
        int                     waited;

        sda    = 1'b0;
        rst_n  = 1'b0;
        scl_m  = 1'b1;
        data_m = 1'b1;
        void'($urandom(RNG_SEED));
        repeat (10) @(posedge sda);
        #(DRIVE_DELAY);
        rst_n = 1'b1;
        tick(5);

        // single byte write and random read of the same location.
        bank1 = BANK_BITS'($urandom);
        off1  = OFFSET_BITS'($urandom);
        write_then_read(bank1, off1, 8'($urandom));

        // sequential writes that cross offset 255 in several banks.
        for (int k = 0; k < 3; k++)
        begin
            bank  = BANK_BITS'($urandom);
            start = OFFSET_BITS'(253 + $urandom % 3);
            open_write(bank, start);
            for (int i = 0; i < QUEUE_DEPTH; i++)
                write_checked(8'($urandom));
            send_stop();
            open_write(bank, start);
            read_bytes(bank, QUEUE_DEPTH);
        end

        // a burst longer than the queue to an idle bank.
        tick(QUEUE_DEPTH * WRITE_CYCLES);
        bank  = BANK_BITS'($urandom);
        start = OFFSET_BITS'($urandom);
        acked = 0;
        open_write(bank, start);
        for (int i = 0; i < QUEUE_DEPTH + 4; i++)
        begin
            value = 8'($urandom);
            send_byte(value, ack);
            // a byte takes 90 clocks, so the first store is still running at byte QUEUE_DEPTH.
            if (i < QUEUE_DEPTH)
                check_ack("burst data acknowledge", ack, ACK_BIT);
            else if (i == QUEUE_DEPTH)
                check_ack("burst data acknowledge", ack, NACK_BIT);
            if (ack == ACK_BIT)
            begin
                ref_write(value);
                acked++;
            end
        end
        send_stop();
        stretch_before = stretch_clocks;
        open_write(bank, start);
        read_bytes(bank, acked);
        if (stretch_clocks == stretch_before)
            abort_run("SCL was not stretched while reading from a busy bank");

        // foreign control byte, then a normal transaction.
        bad_code = DEVICE_CODE ^ 4'(1 + $urandom % 15);
        send_start();
        send_checked({bad_code, 3'($urandom), 1'b0}, NACK_BIT, "foreign control acknowledge");
        send_stop();
        write_then_read(BANK_BITS'($urandom), OFFSET_BITS'($urandom), 8'($urandom));

        // STOP after half a data byte, then a current-address read.
        open_write(bank1, off1);
        for (int i = 0; i < 4; i++)
            clock_bit(~ref_mem[{bank1, off1}][7 - i], seen);
        send_stop();
        read_bytes(bank1, 1);

        waited = 0;
        while (got_q.size() != 0 || exp_q.size() != 0)
        begin
            if (waited == DRAIN_LIMIT)
                abort_run("read data was left unchecked at the end of the run");
            tick(1);
            waited++;
        end
        $display("%0d read bytes checked", bytes_checked);
        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire

/* eeprom_top.sv */
`timescale 1ns/1ns
`default_nettype none

module eeprom_top (
    input  logic sda,
    input  logic rst_n,
    input  logic bus_scl,
    input  logic bus_data,
    output logic bus_data_low,
    output logic bus_scl_low
);
    import eeprom_geom_pkg::*;

    logic       byte_valid;
    logic [7:0] byte_data;
    logic       byte_take;

    bank_port_if bank_ports [NUM_BANKS] ();

    i2c_target u_target (
        .sda          (sda),
        .rst_n        (rst_n),
        .bus_scl      (bus_scl),
        .bus_data     (bus_data),
        .bus_data_low (bus_data_low),
        .bus_scl_low  (bus_scl_low),
        .banks        (bank_ports),
        .byte_valid   (byte_valid),
        .byte_data    (byte_data),
        .byte_take    (byte_take)
    );

    // one bank per block of the control byte.
    for (genvar b = 0; b < NUM_BANKS; b++)
    begin : g_bank
        eeprom_bank u_bank (
            .sda   (sda),
            .rst_n (rst_n),
            .port  (bank_ports[b])
        );
    end

    read_return u_read_return (
        .sda        (sda),
        .rst_n      (rst_n),
        .banks      (bank_ports),
        .byte_valid (byte_valid),
        .byte_data  (byte_data),
        .byte_take  (byte_take)
    );

endmodule

`default_nettype wire

/* i2c_bus_pkg.sv */
`default_nettype none

package i2c_bus_pkg;

    // upper nibble of every control byte this target answers to.
    localparam logic [3:0] DEVICE_CODE = 4'b1010;

    // R/W flag in bit 0 of the control byte.
    localparam logic RW_READ = 1'b1;

    // acknowledge bit values as they appear on the data line.
    localparam logic ACK_BIT  = 1'b0;
    localparam logic NACK_BIT = 1'b1;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_CONTROL,
        ST_ADDRESS,
        ST_WRITE_DATA,
        ST_READ_DATA,
        ST_ACK_OUT,
        ST_ACK_IN
    } target_state_t;

endpackage

`default_nettype wire

/* i2c_target.sv */
`timescale 1ns/1ns
`default_nettype none

module i2c_target (
    input  logic        sda,
    input  logic        rst_n,
    input  logic        bus_scl,
    input  logic        bus_data,
    output logic        bus_data_low,
    output logic        bus_scl_low,
    bank_port_if.issuer banks [eeprom_geom_pkg::NUM_BANKS],
    input  logic        byte_valid,
    input  logic [7:0]  byte_data,
    output logic        byte_take
);
    import eeprom_geom_pkg::*;
    import i2c_bus_pkg::*;

    logic [1:0]             scl_sync;
    logic [1:0]             data_sync;
    logic                   scl_q;
    logic                   data_q;
    logic                   scl_rise;
    logic                   scl_fall;
    logic                   start_det;
    logic                   stop_det;
    logic                   bus_event;

    target_state_t          state;
    target_state_t          ack_next;
    logic [3:0]             bit_cnt;
    logic [7:0]             shift;
    logic [7:0]             rx_byte;
    logic                   ack_bit;
    logic                   ack_got;
    logic                   need_load;
    logic [BANK_BITS-1:0]   bank;
    logic [OFFSET_BITS-1:0] offset;

    logic                   rd_req;
    logic                   rd_outstanding;
    logic                   rd_drop;
    logic [CREDIT_BITS-1:0] credits [NUM_BANKS];
    logic [NUM_BANKS-1:0]   spend;
    logic [NUM_BANKS-1:0]   credit_in;
    logic                   has_credit;
    logic                   wr_issue;
    logic                   rd_issue;
    logic                   issue;
    bank_cmd_t              issue_cmd;
    logic                   read_entry;
    logic                   load_now;

    always_ff @(posedge sda)
    begin
        if (!rst_n)
        begin
            scl_sync  <= 2'b11;
            data_sync <= 2'b11;
            scl_q     <= 1'b1;
            data_q    <= 1'b1;
        end
        else
        begin
            scl_sync  <= {scl_sync[0], bus_scl};
            data_sync <= {data_sync[0], bus_data};
            scl_q     <= scl_sync[1];
            data_q    <= data_sync[1];
        end
    end

    assign scl_rise  = scl_sync[1] && !scl_q;
    assign scl_fall  = !scl_sync[1] && scl_q;
    // START and STOP are data edges while SCL stays high.
    assign start_det = scl_sync[1] && scl_q && data_q && !data_sync[1];
    assign stop_det  = scl_sync[1] && scl_q && !data_q && data_sync[1];
    assign bus_event = start_det || stop_det;
    assign rx_byte   = {shift[6:0], data_sync[1]};

    assign has_credit = credits[bank] != '0;
    assign wr_issue   = (state == ST_WRITE_DATA) && scl_rise && (bit_cnt == 4'd7) && has_credit;
    assign rd_issue   = rd_req && !rd_outstanding && has_credit;
    assign issue      = wr_issue || rd_issue;

    always_comb
    begin
        issue_cmd.write  = wr_issue;
        issue_cmd.offset = offset;
        issue_cmd.data   = rx_byte;
    end

    // the falling edge after which the first bit of a read byte is due.
    assign read_entry = scl_fall &&
                        (((state == ST_ACK_OUT) && (bit_cnt == 4'd9) &&
                          (ack_next == ST_READ_DATA)) ||
                         ((state == ST_ACK_IN) && ack_got));
    assign load_now   = byte_valid && !rd_drop && !bus_event &&
                        (read_entry || ((state == ST_READ_DATA) && need_load));
    // a byte left over from an abandoned read is taken and thrown away.
    assign byte_take  = load_now || (byte_valid && rd_drop);

    for (genvar b = 0; b < NUM_BANKS; b++)
    begin : g_port
        assign spend[b]           = issue && (bank == BANK_BITS'(b));
        assign banks[b].cmd_valid = spend[b];
        assign banks[b].cmd       = issue_cmd;
        assign credit_in[b]       = banks[b].credit;
    end

    always_ff @(posedge sda)
    begin
        if (!rst_n)
        begin
            for (int b = 0; b < NUM_BANKS; b++)
                credits[b] <= CREDIT_BITS'(QUEUE_DEPTH);
        end
        else
        begin
            for (int b = 0; b < NUM_BANKS; b++)
            begin
                if (spend[b] && !credit_in[b])
                    credits[b] <= credits[b] - 1'b1;
                else if (!spend[b] && credit_in[b])
                    credits[b] <= credits[b] + 1'b1;
            end
        end
    end

    always_ff @(posedge sda)
    begin
        if (!rst_n)
        begin
            state          <= ST_IDLE;
            ack_next       <= ST_IDLE;
            bit_cnt        <= '0;
            ack_bit        <= NACK_BIT;
            ack_got        <= 1'b0;
            need_load      <= 1'b0;
            bank           <= '0;
            offset         <= '0;
            rd_req         <= 1'b0;
            rd_outstanding <= 1'b0;
            rd_drop        <= 1'b0;
            bus_data_low   <= 1'b0;
            bus_scl_low    <= 1'b0;
        end
        else
        begin
            case (state)
                ST_CONTROL, ST_ADDRESS, ST_WRITE_DATA:
                begin
                    if (scl_rise)
                    begin
                        shift   <= rx_byte;
                        bit_cnt <= bit_cnt + 4'd1;
                        if (bit_cnt == 4'd7)
                        begin
                            state    <= ST_ACK_OUT;
                            ack_bit  <= ACK_BIT;
                            ack_next <= ST_WRITE_DATA;
                            if (state == ST_CONTROL)
                            begin
                                if (rx_byte[7:4] != DEVICE_CODE)
                                begin
                                    ack_bit  <= NACK_BIT;
                                    ack_next <= ST_IDLE;
                                end
                                else if (rx_byte[0] == RW_READ)
                                begin
                                    bank     <= rx_byte[3:1];
                                    ack_next <= ST_READ_DATA;
                                    rd_req   <= 1'b1;
                                end
                                else
                                begin
                                    bank     <= rx_byte[3:1];
                                    ack_next <= ST_ADDRESS;
                                end
                            end
                            else if (state == ST_ADDRESS)
                                offset <= rx_byte;
                            else if (!has_credit)
                                ack_bit <= NACK_BIT;
                        end
                    end
                end
                ST_ACK_OUT:
                begin
                    if (scl_fall && (bit_cnt == 4'd8))
                    begin
                        bus_data_low <= (ack_bit == ACK_BIT);
                        bit_cnt      <= 4'd9;
                    end
                    else if (scl_fall)
                    begin
                        bus_data_low <= 1'b0;
                        bit_cnt      <= '0;
                        state        <= ack_next;
                        need_load    <= (ack_next == ST_READ_DATA);
                    end
                end
                ST_READ_DATA:
                begin
                    if (scl_rise)
                        bit_cnt <= bit_cnt + 4'd1;
                    else if (scl_fall && (bit_cnt == 4'd8))
                    begin
                        bus_data_low <= 1'b0;
                        bit_cnt      <= '0;
                        ack_got      <= 1'b0;
                        state        <= ST_ACK_IN;
                    end
                    else if (scl_fall)
                    begin
                        shift        <= {shift[6:0], 1'b0};
                        bus_data_low <= !shift[6];
                    end
                end
                ST_ACK_IN:
                begin
                    if (scl_rise)
                    begin
                        ack_got <= (data_sync[1] == ACK_BIT);
                        rd_req  <= (data_sync[1] == ACK_BIT);
                    end
                    else if (scl_fall)
                    begin
                        state     <= ack_got ? ST_READ_DATA : ST_IDLE;
                        need_load <= ack_got;
                    end
                end
                default:
                begin
                    // an idle or unaddressed target waits for the next START.
                end
            endcase

            if (load_now)
            begin
                shift        <= byte_data;
                bus_data_low <= !byte_data[7];
                need_load    <= 1'b0;
            end

            // SCL is released one clock after the first data bit is driven.
            if (read_entry)
                bus_scl_low <= !load_now;
            else
                bus_scl_low <= (state == ST_READ_DATA) && need_load;

            if (issue)
                offset <= offset + 1'b1;

            if (rd_issue)
            begin
                rd_req         <= 1'b0;
                rd_outstanding <= 1'b1;
            end
            else if (byte_take)
                rd_outstanding <= 1'b0;

            if (bus_event && (rd_issue || (rd_outstanding && !byte_take)))
                rd_drop <= 1'b1;
            else if (byte_take)
                rd_drop <= 1'b0;

            // START or STOP abandons whatever byte is in flight.
            if (bus_event)
            begin
                state        <= start_det ? ST_CONTROL : ST_IDLE;
                bit_cnt      <= '0;
                need_load    <= 1'b0;
                rd_req       <= 1'b0;
                bus_data_low <= 1'b0;
                bus_scl_low  <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* read_return.sv */
`timescale 1ns/1ns
`default_nettype none

module read_return (
    input  logic        sda,
    input  logic        rst_n,
    bank_port_if.reader banks [eeprom_geom_pkg::NUM_BANKS],
    output logic        byte_valid,
    output logic [7:0]  byte_data,
    input  logic        byte_take
);
    import eeprom_geom_pkg::*;

    logic [NUM_BANKS-1:0] hit;
    logic [7:0]           rd_bus [NUM_BANKS];
    logic [7:0]           merged;

    for (genvar b = 0; b < NUM_BANKS; b++)
    begin : g_port
        assign hit[b]    = banks[b].rd_valid;
        assign rd_bus[b] = banks[b].rd_data;
    end

    // only one read is ever in flight, so an OR of the answers is enough.
    always_comb
    begin
        merged = '0;
        for (int b = 0; b < NUM_BANKS; b++)
            merged = merged | (hit[b] ? rd_bus[b] : 8'h00);
    end

    always_ff @(posedge sda)
    begin
        if (|hit)
            byte_data <= merged;
    end

    always_ff @(posedge sda)
    begin
        if (!rst_n)
            byte_valid <= 1'b0;
        else if (|hit)
            byte_valid <= 1'b1;
        else if (byte_take)
            byte_valid <= 1'b0;
    end

endmodule

`default_nettype wire
